// File: mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// first instruction fetch after reset.
`define MIPS_RESET_VECTOR 32'h0000_0004

// a jump to this address stops the core.
`define MIPS_HALT_ADDR 32'h0000_0000

// result register $v0, exported at the top level.
`define MIPS_REG_V0 5'd2

// register $zero always reads as 0.
`define MIPS_REG_ZERO 5'd0

// word size in bytes, pc step.
`define MIPS_WORD_BYTES 32'd4

`endif

// File: mips_pkg.sv
package mips_pkg;

    // major opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // funct field for OP_SPECIAL.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_MFHI = 6'h10,
        FN_MTHI = 6'h11,
        FN_MFLO = 6'h12,
        FN_MTLO = 6'h13,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, viewed as R-type or I-type.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

endpackage

// File: mips_mem_if.sv
`timescale 1ns/1ps

interface mips_mem_if;

    // request side, held stable by the core until done.
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;

    // completion side. done is a single-cycle pulse.
    logic        done;
    logic [31:0] rdata;   // valid only while done is high.

    modport core (
        output req, we, addr, wdata,
        input  done, rdata
    );

    modport bus (
        input  req, we, addr, wdata,
        output done, rdata
    );

endinterface

// File: avalon_master.sv
`timescale 1ns/1ps

module avalon_master (
    input  logic        clk,
    input  logic        reset,
    mips_mem_if.bus     mem,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic [31:0] readdata,
    input  logic        waitrequest
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t state;
    logic   xfer_done;

    // strobe is up and the slave accepted it.
    assign xfer_done = (state == BUSY) && !waitrequest;

    assign mem.done  = xfer_done;
    assign mem.rdata = readdata;   // sampled by the core on done.

    assign byteenable = 4'b1111;   // word transfers only.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (mem.req) begin
                        state <= BUSY;
                        read  <= !mem.we;
                        write <= mem.we;
                    end
                end
                BUSY: begin
                    if (!waitrequest) begin   // completing cycle.
                        state <= IDLE;
                        read  <= 1'b0;
                        write <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address and data captured once per request, then held.
    always_ff @(posedge clk) begin
        if (state == IDLE && mem.req) begin
            address   <= mem.addr;
            writedata <= mem.wdata;
        end
    end

endmodule

// File: mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
    input  mips_pkg::instr_t  instr,
    output mips_pkg::alu_op_e alu_op,
    output logic              use_imm,
    output logic              imm_zero_ext,
    output logic              reg_write,
    output logic [4:0]        dest,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch_eq,
    output logic              branch_ne,
    output logic              jump_reg,
    output logic              hi_write,
    output logic              lo_write,
    output logic              from_hi,
    output logic              from_lo
);

    always_comb begin
        // default is a no-op.
        alu_op       = mips_pkg::ALU_ADD;
        use_imm      = 1'b0;
        imm_zero_ext = 1'b0;
        reg_write    = 1'b0;
        dest         = instr.i.rt;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        branch_eq    = 1'b0;
        branch_ne    = 1'b0;
        jump_reg     = 1'b0;
        hi_write     = 1'b0;
        lo_write     = 1'b0;
        from_hi      = 1'b0;
        from_lo      = 1'b0;

        case (instr.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                dest = instr.r.rd;   // R-type writes rd.
                case (instr.r.funct)
                    mips_pkg::FN_ADDU: begin alu_op = mips_pkg::ALU_ADD; reg_write = 1'b1; end
                    mips_pkg::FN_SUBU: begin alu_op = mips_pkg::ALU_SUB; reg_write = 1'b1; end
                    mips_pkg::FN_AND:  begin alu_op = mips_pkg::ALU_AND; reg_write = 1'b1; end
                    mips_pkg::FN_OR:   begin alu_op = mips_pkg::ALU_OR;  reg_write = 1'b1; end
                    mips_pkg::FN_XOR:  begin alu_op = mips_pkg::ALU_XOR; reg_write = 1'b1; end
                    mips_pkg::FN_SLT:  begin alu_op = mips_pkg::ALU_SLT; reg_write = 1'b1; end
                    mips_pkg::FN_JR:   jump_reg = 1'b1;
                    mips_pkg::FN_MTHI: hi_write = 1'b1;
                    mips_pkg::FN_MTLO: lo_write = 1'b1;
                    mips_pkg::FN_MFHI: begin from_hi = 1'b1; reg_write = 1'b1; end
                    mips_pkg::FN_MFLO: begin from_lo = 1'b1; reg_write = 1'b1; end
                    default: ;   // unknown funct, nothing happens.
                endcase
            end
            mips_pkg::OP_ADDIU: begin use_imm = 1'b1; reg_write = 1'b1; end
            mips_pkg::OP_ANDI: begin
                alu_op = mips_pkg::ALU_AND;
                use_imm = 1'b1;
                imm_zero_ext = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op = mips_pkg::ALU_OR;
                use_imm = 1'b1;
                imm_zero_ext = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::OP_XORI: begin
                alu_op = mips_pkg::ALU_XOR;
                use_imm = 1'b1;
                imm_zero_ext = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::OP_LUI: begin alu_op = mips_pkg::ALU_LUI; use_imm = 1'b1; reg_write = 1'b1; end
            mips_pkg::OP_LW: begin use_imm = 1'b1; mem_read = 1'b1; reg_write = 1'b1; end
            mips_pkg::OP_SW: begin use_imm = 1'b1; mem_write = 1'b1; end
            mips_pkg::OP_BEQ: begin alu_op = mips_pkg::ALU_SUB; branch_eq = 1'b1; end
            mips_pkg::OP_BNE: begin alu_op = mips_pkg::ALU_SUB; branch_ne = 1'b1; end
            default: ;
        endcase
    end

endmodule

// File: mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              zero
);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;   // also the branch compare.
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_SLT: begin
                // signed compare.
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            mips_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = 32'd0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    assign v0 = regs[`MIPS_REG_V0];   // updates the cycle after writeback.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != `MIPS_REG_ZERO) begin
            regs[waddr] <= wdata;   // $zero never written.
        end
    end

endmodule

// File: mips_core.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core (
    input  logic        clk,
    input  logic        reset,
    mips_mem_if.core    mem,
    output logic        active,
    output logic [31:0] register_v0
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } state_t;

    state_t            state;
    logic [31:0]       pc;
    mips_pkg::instr_t  ir;
    logic [31:0]       hi;
    logic [31:0]       lo;
    logic [31:0]       result_q;   // value waiting for writeback.

    mips_pkg::alu_op_e alu_op;
    logic              use_imm;
    logic              imm_zero_ext;
    logic              reg_write;
    logic [4:0]        dest;
    logic              mem_read;
    logic              mem_write;
    logic              branch_eq;
    logic              branch_ne;
    logic              jump_reg;
    logic              hi_write;
    logic              lo_write;
    logic              from_hi;
    logic              from_lo;

    logic [31:0]       rs_val;
    logic [31:0]       rt_val;
    logic [31:0]       imm_ext;
    logic [31:0]       alu_b;
    logic [31:0]       alu_result;
    logic              alu_zero;
    logic [31:0]       pc_plus4;
    logic [31:0]       branch_target;
    logic              take_branch;

    mips_decoder u_decoder (
        .instr(ir), .alu_op(alu_op), .use_imm(use_imm), .imm_zero_ext(imm_zero_ext),
        .reg_write(reg_write), .dest(dest), .mem_read(mem_read), .mem_write(mem_write),
        .branch_eq(branch_eq), .branch_ne(branch_ne), .jump_reg(jump_reg),
        .hi_write(hi_write), .lo_write(lo_write), .from_hi(from_hi), .from_lo(from_lo)
    );

    mips_regfile u_regfile (
        .clk(clk), .reset(reset), .raddr_a(ir.r.rs), .raddr_b(ir.r.rt),
        .rdata_a(rs_val), .rdata_b(rt_val), .we((state == S_WB) && reg_write),
        .waddr(dest), .wdata(result_q), .v0(register_v0)
    );

    mips_alu u_alu (.op(alu_op), .a(rs_val), .b(alu_b), .result(alu_result), .zero(alu_zero));

    assign imm_ext = imm_zero_ext ? {16'h0000, ir.i.imm} : {{16{ir.i.imm[15]}}, ir.i.imm};
    assign alu_b = use_imm ? imm_ext : rt_val;

    assign pc_plus4      = pc + `MIPS_WORD_BYTES;
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};   // sext(imm) << 2.
    assign take_branch   = (branch_eq && alu_zero) || (branch_ne && !alu_zero);

    // bus request straight from the state.
    assign mem.req   = (state == S_FETCH) || (state == S_MEM);
    assign mem.we    = (state == S_MEM) && mem_write;
    assign mem.addr  = (state == S_MEM) ? result_q : pc;
    assign mem.wdata = rt_val;

    assign active = (state != S_HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
            pc    <= `MIPS_RESET_VECTOR;
            ir    <= '0;   // decodes as a no-op.
            hi    <= 32'd0;
            lo    <= 32'd0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (mem.done) begin
                        ir    <= mem.rdata;
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (jump_reg && rs_val == `MIPS_HALT_ADDR) begin
                        state <= S_HALT;   // jr $zero ends the program.
                    end else begin
                        if (jump_reg) pc <= rs_val;
                        else if (take_branch) pc <= branch_target;
                        else pc <= pc_plus4;
                        state <= (mem_read || mem_write) ? S_MEM : S_WB;
                    end
                end
                S_MEM: if (mem.done) state <= S_WB;   // stall until the bus is done.
                S_WB: begin
                    if (hi_write) hi <= rs_val;
                    if (lo_write) lo <= rs_val;
                    state <= S_FETCH;
                end
                S_HALT: state <= S_HALT;
                default: state <= S_HALT;
            endcase
        end
    end

    // result for writeback, from alu, hi/lo or the load.
    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            if (from_hi) result_q <= hi;
            else if (from_lo) result_q <= lo;
            else result_q <= alu_result;
        end else if (state == S_MEM && mem.done && mem_read) begin
            result_q <= mem.rdata;
        end
    end

endmodule

// File: mips_cpu_top.sv
`timescale 1ns/1ps

module mips_cpu_top (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic [31:0] readdata,
    input  logic        waitrequest
);

    mips_mem_if mem_bus ();

    mips_core u_core (
        .clk         (clk),
        .reset       (reset),
        .mem         (mem_bus.core),
        .active      (active),
        .register_v0 (register_v0)
    );

    // one port for both fetches and data.
    avalon_master u_master (
        .clk         (clk),
        .reset       (reset),
        .mem         (mem_bus.bus),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

endmodule

// File: avalon_ram_model.sv
`timescale 1ns/1ps

module avalon_ram_model (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    logic [31:0] mem [64];
    logic [15:0] lfsr_state;
    logic        in_xfer;
    logic [1:0]  wait_left;

    // transfer record, read by the testbench.
    int          rd_count;
    int          wr_count;
    logic [31:0] first_rd_addr;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    logic [3:0]  last_wr_be;

    // galois lfsr, taps 16,14,13,11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    task automatic clear_mem();
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'd0;   // zero word decodes as a no-op.
        end
    endtask

    task automatic load_word(input int byte_addr, input logic [31:0] data);
        mem[byte_addr / 4] = data;
    endtask

    initial begin
        lfsr_state  = 16'd50;
        in_xfer     = 1'b0;
        wait_left   = 2'd0;
        readdata    = 32'd0;
        waitrequest = 1'b0;
    end

    // slave outputs change on the falling edge.
    always @(negedge clk) begin
        logic b_hi;
        logic b_lo;
        if (reset) begin
            in_xfer     = 1'b0;
            waitrequest = 1'b0;
        end else begin
            if (in_xfer && !waitrequest) in_xfer = 1'b0;   // finished last cycle.
            if (read || write) begin
                if (!in_xfer) begin
                    in_xfer = 1'b1;
                    take_bit(b_hi);
                    take_bit(b_lo);
                    wait_left = {b_hi, b_lo};   // 0 to 3 wait cycles.
                end
                if (wait_left != 2'd0) begin
                    waitrequest = 1'b1;
                    wait_left   = wait_left - 2'd1;
                end else begin
                    waitrequest = 1'b0;
                    readdata    = read ? mem[address[7:2]] : 32'd0;
                end
            end else begin
                waitrequest = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            rd_count      = 0;
            wr_count      = 0;
            first_rd_addr = 32'hFFFF_FFFF;
            last_wr_addr  = 32'd0;
            last_wr_data  = 32'd0;
            last_wr_be    = 4'd0;
        end else if ((read || write) && !waitrequest) begin
            if (write) begin
                mem[address[7:2]] = writedata;
                wr_count++;
                last_wr_addr = address;
                last_wr_data = writedata;
                last_wr_be   = byteenable;
            end else begin
                if (rd_count == 0) first_rd_addr = address;
                rd_count++;
            end
        end
    end

endmodule

// File: mips_cpu_sva.sv
`timescale 1ns/1ps

module mips_cpu_sva (
    input logic        clk,
    input logic        reset,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic        active,
    input logic [31:0] address,
    input logic [31:0] writedata
);

    a_no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write are high together");

    // a stalled transfer keeps its address and data.
    a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(writedata))
        else $error("address or writedata changed during waitrequest");

    a_quiet_halt: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus strobe seen after halt");

endmodule

bind mips_cpu_top mips_cpu_sva sva_i (.*);

// File: mips_cpu_tb.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_cpu_tb;

    localparam int NUM_PROGS = 5;
    localparam int MAX_WORDS = 15;   // program must end below 0x40.
    localparam int TIMEOUT   = 2000;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic        waitrequest;

    logic [31:0] prog [NUM_PROGS][MAX_WORDS];
    int          prog_len [NUM_PROGS];
    logic [31:0] exp_v0 [NUM_PROGS];
    logic        has_store [NUM_PROGS];
    logic [31:0] exp_st_addr [NUM_PROGS];
    logic [31:0] exp_st_data [NUM_PROGS];

    int errors;
    int checks;
    int reads_after_halt;

    mips_cpu_top mips_cpu_top_i (.*);

    avalon_ram_model ram_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) reads_after_halt <= 0;
        else if (!active && read) reads_after_halt <= reads_after_halt + 1;
    end

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input logic [5:0] funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_word(input int p, input logic [31:0] w);
        prog[p][prog_len[p]] = w;
        prog_len[p]++;
    endtask

    task automatic build_table();
        logic [31:0] r8;
        logic [31:0] r9;
        logic [31:0] r10;
        logic [31:0] r11;
        logic [31:0] r12;
        logic [31:0] r13;
        logic [31:0] v;
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_len[p]  = 0;
            has_store[p] = 1'b0;
            exp_st_addr[p] = 32'd0;
            exp_st_data[p] = 32'd0;
        end
        // hi path.
        add_word(0, enc_i(6'h09, 0, 2, 16'hFFFF));
        add_word(0, enc_r(2, 0, 0, 6'h11));
        add_word(0, enc_i(6'h09, 0, 2, 16'h0000));
        add_word(0, enc_r(0, 0, 2, 6'h10));
        add_word(0, enc_r(0, 0, 0, 6'h08));
        exp_v0[0] = 32'hFFFF_FFFF;   // sign extended -1.
        // lo path.
        add_word(1, enc_i(6'h09, 0, 2, 16'h1234));
        add_word(1, enc_r(2, 0, 0, 6'h13));
        add_word(1, enc_i(6'h09, 0, 2, 16'h0000));
        add_word(1, enc_r(0, 0, 2, 6'h12));
        add_word(1, enc_r(0, 0, 0, 6'h08));
        exp_v0[1] = 32'h0000_1234;
        // alu mix folded step by step.
        add_word(2, enc_i(6'h0F, 0, 8, 16'h8000));
        r8 = {16'h8000, 16'h0000};
        add_word(2, enc_i(6'h0D, 8, 8, 16'h00F0));
        r8 = r8 | 32'h0000_00F0;
        add_word(2, enc_i(6'h09, 0, 9, 16'hFFF0));
        r9 = {16'hFFFF, 16'hFFF0};
        add_word(2, enc_i(6'h0C, 9, 10, 16'hFFFF));
        r10 = r9 & 32'h0000_FFFF;   // zero extended.
        add_word(2, enc_i(6'h0E, 10, 11, 16'h8001));
        r11 = r10 ^ 32'h0000_8001;
        add_word(2, enc_r(10, 11, 2, 6'h21));
        v = r10 + r11;
        add_word(2, enc_r(2, 8, 2, 6'h23));
        v = v - r8;
        add_word(2, enc_r(2, 9, 12, 6'h24));
        r12 = v & r9;
        add_word(2, enc_r(12, 11, 2, 6'h25));
        v = r12 | r11;
        add_word(2, enc_r(2, 10, 2, 6'h26));
        v = v ^ r10;
        add_word(2, enc_r(8, 10, 13, 6'h2A));
        // differing signs decide on their own.
        r13 = (r8[31] != r10[31]) ? {31'd0, r8[31]} : {31'd0, r8 < r10};
        add_word(2, enc_r(2, 13, 2, 6'h21));
        v = v + r13;
        add_word(2, enc_r(0, 0, 0, 6'h08));
        exp_v0[2] = v;
        // store then load back.
        add_word(3, enc_i(6'h0F, 0, 8, 16'hA5A5));
        add_word(3, enc_i(6'h0D, 8, 8, 16'h5A5A));
        add_word(3, enc_i(6'h09, 8, 9, 16'h0003));
        add_word(3, enc_i(6'h2B, 0, 9, 16'h0040));
        add_word(3, enc_i(6'h23, 0, 2, 16'h0040));
        add_word(3, enc_r(0, 0, 0, 6'h08));
        v = ({16'hA5A5, 16'h0000} | 32'h0000_5A5A) + 32'd3;
        exp_v0[3]      = v;
        has_store[3]   = 1'b1;
        exp_st_addr[3] = 32'h0000_0040;
        exp_st_data[3] = v;
        // branches taken and not taken.
        add_word(4, enc_i(6'h09, 0, 2, 16'h0000));
        add_word(4, enc_i(6'h09, 0, 8, 16'h0005));
        add_word(4, enc_i(6'h04, 8, 0, 16'h0001));   // not taken.
        add_word(4, enc_i(6'h09, 2, 2, 16'h0001));
        add_word(4, enc_i(6'h05, 8, 0, 16'h0001));   // taken.
        add_word(4, enc_i(6'h09, 2, 2, 16'h0010));
        add_word(4, enc_i(6'h09, 2, 2, 16'h0100));
        add_word(4, enc_i(6'h04, 8, 8, 16'h0001));   // taken.
        add_word(4, enc_i(6'h09, 2, 2, 16'h1000));
        add_word(4, enc_i(6'h05, 8, 8, 16'h0001));   // not taken.
        add_word(4, enc_i(6'h09, 2, 2, 16'h2000));
        add_word(4, enc_r(0, 0, 0, 6'h08));
        exp_v0[4] = 32'h0000_0001 + 32'h0000_0100 + 32'h0000_2000;
    endtask

    task automatic compare_word(input string sig, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("FAIL time %0t: %s expected %h got %h", $time, sig, exp, act);
            errors++;
        end
    endtask

    initial begin
        int cycles;
        errors = 0;
        checks = 0;
        reset  = 1'b1;
        build_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clk);
            reset = 1'b1;
            ram_i.clear_mem();
            for (int w = 0; w < prog_len[p]; w++) begin
                ram_i.load_word(`MIPS_RESET_VECTOR + 4 * w, prog[p][w]);
            end
            repeat (3) @(negedge clk);
            reset = 1'b0;
            compare_word("active", 32'(1'b1), 32'(active));
            cycles = 0;
            while (active && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (active) begin
                $display("timeout: program %0d did not halt within %0d cycles", p, TIMEOUT);
                errors++;
            end else begin
                repeat (10) @(negedge clk);   // window for stray reads.
                compare_word("register_v0", exp_v0[p], register_v0);
                compare_word("first read address", `MIPS_RESET_VECTOR, ram_i.first_rd_addr);
                compare_word("reads after halt", 32'd0, 32'(reads_after_halt));
                if (has_store[p]) begin
                    compare_word("write count", 32'd1, 32'(ram_i.wr_count));
                    compare_word("address", exp_st_addr[p], ram_i.last_wr_addr);
                    compare_word("byteenable", 32'h0000_000F, 32'(ram_i.last_wr_be));
                    compare_word("writedata", exp_st_data[p], ram_i.last_wr_data);
                end else begin
                    compare_word("write count", 32'd0, 32'(ram_i.wr_count));
                end
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
mips_pkg.sv
mips_mem_if.sv
avalon_master.sv
mips_decoder.sv
mips_alu.sv
mips_regfile.sv
mips_core.sv
mips_cpu_top.sv
avalon_ram_model.sv
mips_cpu_sva.sv
mips_cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module mips_cpu_tb -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error"
fi
cat sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
